// File: project.f
logic/aes_pkg.sv
logic/aes_sbox.sv
logic/aes_key_step.sv
logic/aes_round.sv
logic/aes_core.sv
logic/aes_spi.sv
logic/aes_spi_top.sv
verification/aes_spi_tb.sv

// File: run.sh
#!/bin/sh
# build and run the aes spi testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module aes_spi_tb \
  -f project.f -o aes_spi_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/aes_spi_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

// File: verification/aes_spi_tb.sv
// aes spi accelerator testbench
`timescale 1ns/1ps

module aes_spi_tb;
  import aes_pkg::*;

  // one known-answer vector, key and plaintext in and the ciphertext expected back
  typedef struct packed {
    aes_key_t   key;
    aes_block_t plaintext;
    aes_block_t expected;
  } vector_t;

  localparam int num_vectors = 5;
  // done is due 11 cycles after the start edge, this leaves plenty of room
  localparam int done_limit  = 40;
  // every vector needs about 400 cycles of 100 ns
  localparam int watchdog_ns = (num_vectors * 420 + 20) * 100;

  logic sclk;
  logic rst;
  logic load;
  logic mosi;
  logic miso;
  logic done;

  vector_t    vectors [0:num_vectors-1];
  aes_block_t result;
  int         errors;
  int         hangs;
  int         latency;
  logic       ok;
  string      phase;

  aes_spi_top dut (
    .sclk (sclk),
    .rst  (rst),
    .load (load),
    .mosi (mosi),
    .miso (miso),
    .done (done)
  );

  // 100 ns clock period
  always #50 sclk = ~sclk;

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors = errors + 1;
      $display("Error at %0t: %s expected %b got %b", $time, what, exp, got);
    end
  endtask

  task automatic check_block(input aes_block_t got, input aes_block_t exp, input string what);
    if (got.bits !== exp.bits) begin
      errors = errors + 1;
      $display("Error at %0t: %s expected %h got %h", $time, what, exp.bits, got.bits);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      errors = errors + 1;
      $display("Error at %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  // shift plaintext then key into the chain, msb first, with load held high
  task automatic send_block(input aes_block_t plaintext, input aes_key_t key);
    logic [255:0] stream;
    stream = {plaintext.bits, key};
    for (int i = 0; i < 256; i++) begin
      @(posedge sclk);
      #5;
      // the first posedge that sees load high clears done
      if (i >= 1) begin
        check_bit(done, 1'b0, "done while loading");
      end
      // miso settles low at the falling edge after done drops
      if (i >= 2) begin
        check_bit(miso, 1'b0, "miso while loading");
      end
      load = 1'b1;
      mosi = stream[255 - i];
    end
  endtask

  // drop load and count the posedges after the start edge until done is seen
  task automatic wait_done(output int cycles, output logic seen);
    cycles = 0;
    seen   = 1'b0;
    // this posedge takes in the last key bit
    @(posedge sclk);
    #5;
    load = 1'b0;
    mosi = 1'b0;
    // the next posedge is the start strobe
    @(posedge sclk);
    #5;
    check_bit(done, 1'b0, "done at the start edge");
    while (!seen && cycles < done_limit) begin
      @(posedge sclk);
      #5;
      cycles = cycles + 1;
      if (done === 1'b1) begin
        seen = 1'b1;
      end else begin
        check_bit(miso, 1'b0, "miso before done");
      end
    end
    if (!seen) begin
      $display("timeout: done never rose after load fell");
    end
  endtask

  // sample miso just before each of the next 128 rising edges
  task automatic read_block(output aes_block_t got);
    got.bits = '0;
    for (int i = 0; i < 128; i++) begin
      @(negedge sclk);
      #45;
      got.bits[127 - i] = miso;
      check_bit(done, 1'b1, "done during readout");
    end
  endtask

  initial begin
    sclk    = 1'b0;
    rst     = 1'b1;
    load    = 1'b0;
    mosi    = 1'b0;
    errors  = 0;
    hangs   = 0;
    latency = 0;
    ok      = 1'b0;
    phase   = "reset";

    // fips-197 appendix c.1
    vectors[0].key            = 128'h000102030405060708090a0b0c0d0e0f;
    vectors[0].plaintext.bits = 128'h00112233445566778899aabbccddeeff;
    vectors[0].expected.bits  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    // fips-197 appendix b
    vectors[1].key            = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    vectors[1].plaintext.bits = 128'h3243f6a8885a308d313198a2e0370734;
    vectors[1].expected.bits  = 128'h3925841d02dc09fbdc118597196a0b32;
    // sp 800-38a ecb block 2, its ciphertext msb is 1 so the first miso bit
    // really comes from the bypass and must drop again while the next block loads
    vectors[2].key            = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    vectors[2].plaintext.bits = 128'hae2d8a571e03ac9c9eb76fac45af8e51;
    vectors[2].expected.bits  = 128'hf5d3d58503b9699de785895a96fdbaaf;
    // all-zero key and block
    vectors[3].key            = 128'h0;
    vectors[3].plaintext.bits = 128'h0;
    vectors[3].expected.bits  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    // appendix b again right after the zero vector, so nothing may carry over
    vectors[4] = vectors[1];

    repeat (3) @(posedge sclk);
    #5;
    rst = 1'b0;

    // nothing has run yet, both outputs must sit at 0
    phase = "idle check after reset";
    repeat (4) begin
      @(posedge sclk);
      #5;
      check_bit(done, 1'b0, "done after reset");
      check_bit(miso, 1'b0, "miso after reset");
    end

    for (int n = 0; n < num_vectors && hangs == 0; n++) begin
      phase = $sformatf("loading vector %0d", n);
      send_block(vectors[n].plaintext, vectors[n].key);
      phase = $sformatf("waiting for done on vector %0d", n);
      wait_done(latency, ok);
      if (!ok) begin
        hangs = hangs + 1;
      end else begin
        check_count(latency, 11, "cycles from start edge to done");
        // the bypass shows the msb in the cycle done rises
        check_bit(miso, vectors[n].expected.bits[127], "first miso bit");
        phase = $sformatf("reading vector %0d", n);
        read_block(result);
        check_block(result, vectors[n].expected, $sformatf("ciphertext of vector %0d", n));
      end
    end

    $display("finished with %0d errors and %0d timeouts", errors, hangs);
    if (errors == 0 && hangs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // ends a run that stopped making progress
  initial begin
    #(watchdog_ns);
    $display("watchdog expired while %s", phase);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: logic/aes_spi_top.sv
// aes-128 spi accelerator top
`timescale 1ns/1ps

module aes_spi_top (
  input  logic sclk,
  input  logic rst,
  input  logic load,
  input  logic mosi,
  output logic miso,
  output logic done
);
  import aes_pkg::*;

  // block and key coming in from the host, result going back
  aes_block_t plaintext;
  aes_key_t   key;
  aes_block_t ciphertext;

  // serial side, runs on both edges of sclk
  aes_spi u_spi (
    .sclk       (sclk),
    .rst        (rst),
    .mosi       (mosi),
    .done       (done),
    .ciphertext (ciphertext),
    .miso       (miso),
    .plaintext  (plaintext),
    .key        (key)
  );

  // cipher side, started by load falling
  aes_core u_core (
    .sclk       (sclk),
    .rst        (rst),
    .load       (load),
    .plaintext  (plaintext),
    .key        (key),
    .ciphertext (ciphertext),
    .done       (done)
  );

endmodule

// File: logic/aes_spi.sv
// spi shift interface for the aes core
`timescale 1ns/1ps

module aes_spi (
  input  logic                sclk,
  input  logic                rst,
  input  logic                mosi,
  input  logic                done,
  input  aes_pkg::aes_block_t ciphertext,
  output logic                miso,
  output aes_pkg::aes_block_t plaintext,
  output aes_pkg::aes_key_t   key
);

  logic [127:0] out_shift;
  logic         was_done;
  logic         miso_q;

  // one 256-bit chain, plaintext on top and key below
  // mosi enters the key lsb, the key msb spills into the plaintext lsb
  // so the host sends plaintext first and then key, both msb first
  always_ff @(posedge sclk) begin
    {plaintext.bits, key} <= {plaintext.bits[126:0], key, mosi};
  end

  // keep loading the ciphertext until done has been seen at a falling edge
  // after that the register moves one bit toward the top on every posedge
  always_ff @(posedge sclk) begin
    if (!was_done) begin
      out_shift <= ciphertext.bits;
    end else begin
      out_shift <= {out_shift[126:0], 1'b0};
    end
  end

  // miso changes on the falling edge, half a cycle ahead of the host sampling
  // the bit stays low while no result is ready
  always_ff @(negedge sclk) begin
    if (rst) begin
      was_done <= 1'b0;
      miso_q   <= 1'b0;
    end else begin
      was_done <= done;
      miso_q   <= done & out_shift[127];
    end
  end

  // before the first falling edge with done high, show the ciphertext msb directly
  assign miso = (done && !was_done) ? ciphertext.bits[127] : miso_q;

endmodule

// File: logic/aes_core.sv
// iterative aes-128 encryption core
`timescale 1ns/1ps

module aes_core (
  input  logic                sclk,
  input  logic                rst,
  input  logic                load,
  input  aes_pkg::aes_block_t plaintext,
  input  aes_pkg::aes_key_t   key,
  output aes_pkg::aes_block_t ciphertext,
  output logic                done
);
  import aes_pkg::*;

  aes_block_t state;
  aes_block_t next_state;
  aes_key_t   round_key;
  aes_key_t   next_key;
  logic [7:0] rcon;
  logic [7:0] next_rcon;
  aes_round_t round;
  logic       load_q;
  logic       start;
  logic       step;
  logic       final_round;

  // load dropping between two posedges starts a new block
  assign start = load_q && !load;

  // round counts 1 to num_rounds while rounds run, 0 when idle
  assign step        = (round != 4'd0) && (round <= num_rounds);
  assign final_round = (round == num_rounds);

  // the round consumes the key that the schedule derives in the same cycle
  aes_key_step u_key_step (
    .round_key (round_key),
    .rcon      (rcon),
    .next_key  (next_key),
    .next_rcon (next_rcon)
  );

  aes_round u_round (
    .state       (state),
    .round_key   (next_key),
    .final_round (final_round),
    .next_state  (next_state)
  );

  // sequencer
  // done comes one cycle after the last round so that the spi block
  // captures a ciphertext that already sits in the state register
  always_ff @(posedge sclk) begin
    if (rst) begin
      load_q <= 1'b0;
      round  <= 4'd0;
      done   <= 1'b0;
    end else begin
      load_q <= load;
      if (load) begin
        round <= 4'd0;
        done  <= 1'b0;
      end else if (start) begin
        round <= 4'd1;
      end else if (round == num_rounds + 4'd1) begin
        round <= 4'd0;
        done  <= 1'b1;
      end else if (step) begin
        round <= round + 4'd1;
      end
    end
  end

  // initial addroundkey on start, then one round per cycle
  always_ff @(posedge sclk) begin
    if (start) begin
      state.bits <= plaintext.bits ^ key;
      round_key  <= key;
      rcon       <= rcon_init;
    end else if (step) begin
      state     <= next_state;
      round_key <= next_key;
      rcon      <= next_rcon;
    end
  end

  // state holds still once the rounds stop
  assign ciphertext = state;

endmodule

// File: logic/aes_round.sv
// aes encryption round
`timescale 1ns/1ps

module aes_round (
  input  aes_pkg::aes_block_t state,
  input  aes_pkg::aes_key_t   round_key,
  input  logic                final_round,
  output aes_pkg::aes_block_t next_state
);
  import aes_pkg::*;

  logic [0:15][7:0] sub_bytes;
  aes_block_t       shifted;
  aes_block_t       mixed;

  // mixcolumns on one column, top byte is row 0
  function automatic logic [31:0] mix_column(input logic [31:0] col);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    // rows of the circulant matrix 02 03 01 01, where 03*a is xtime(a) ^ a
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  // subbytes with one s-box per state byte
  genvar i;
  generate
    for (i = 0; i < 16; i++) begin : g_sub
      aes_sbox u_sbox (
        .in  (state.bytes[i]),
        .out (sub_bytes[i])
      );
    end
  endgenerate

  // shiftrows rotates row r left by r columns
  // so row r of column c comes from column c + r
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.bytes[4*c + r] = sub_bytes[4*((c + r) % 4) + r];
      end
    end
  end

  // the last round leaves the columns unmixed
  always_comb begin
    mixed = shifted;
    if (!final_round) begin
      for (int c = 0; c < 4; c++) begin
        mixed.bits[127 - 32*c -: 32] = mix_column(shifted.bits[127 - 32*c -: 32]);
      end
    end
  end

  // addroundkey
  assign next_state.bits = mixed.bits ^ round_key;

endmodule

// File: logic/aes_key_step.sv
// aes-128 key expansion step
`timescale 1ns/1ps

module aes_key_step (
  input  aes_pkg::aes_key_t round_key,
  input  logic [7:0]        rcon,
  output aes_pkg::aes_key_t next_key,
  output logic [7:0]        next_rcon
);
  import aes_pkg::*;

  aes_word_t rot_word;
  aes_word_t sub_word;

  // rotword moves the top byte of the last word to the bottom
  assign rot_word = {round_key[3][23:0], round_key[3][31:24]};

  // subword runs each byte of the rotated word through its own s-box
  genvar i;
  generate
    for (i = 0; i < 4; i++) begin : g_sub
      aes_sbox u_sbox (
        .in  (rot_word[8*i +: 8]),
        .out (sub_word[8*i +: 8])
      );
    end
  endgenerate

  // the round constant only touches the top byte of the first word
  // every later word chains on the word just produced
  always_comb begin
    next_key[0] = round_key[0] ^ sub_word ^ {rcon, 24'h000000};
    next_key[1] = round_key[1] ^ next_key[0];
    next_key[2] = round_key[2] ^ next_key[1];
    next_key[3] = round_key[3] ^ next_key[2];
  end

  // the next constant is this one doubled in gf(2^8)
  assign next_rcon = xtime(rcon);

endmodule

// File: logic/aes_sbox.sv
// aes forward substitution box
`timescale 1ns/1ps

module aes_sbox (
  input  logic [7:0] in,
  output logic [7:0] out
);

  // one row of the fips-197 table, picked by the high nibble
  logic [127:0] row;

  // each row holds sixteen entries, column 0 in the top byte
  always_comb begin
    case (in[7:4])
      4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
      4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
      4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
      4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
      4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
      4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
      4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
      4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
      4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
      4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
      4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
      4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
      4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
      4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
      4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
      4'hf: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
    endcase
  end

  // the low nibble selects the column inside the row
  // column 0 is the top byte, so the index counts down from bit 127
  assign out = row[8*(15 - in[3:0]) +: 8];

endmodule

// File: logic/aes_pkg.sv
// aes-128 shared types
package aes_pkg;

  // one 32-bit word of the key schedule
  typedef logic [31:0] aes_word_t;

  // a 128-bit round key as four schedule words, word 0 in the top bits
  typedef aes_word_t [0:3] aes_key_t;

  // a cipher block seen either as a flat vector or as sixteen bytes
  // the flat view feeds the serial shift chain
  // the byte view follows fips-197 column order, so byte 4*c + r is row r of column c
  // byte 0 is the most significant byte of the flat view
  typedef union packed {
    logic [127:0]     bits;
    logic [0:15][7:0] bytes;
  } aes_block_t;

  // round counter wide enough for the ten rounds and the finishing step
  typedef logic [3:0] aes_round_t;

  // number of cipher rounds for a 128-bit key
  localparam aes_round_t num_rounds = 4'd10;

  // round constant used by the first key expansion step
  localparam logic [7:0] rcon_init = 8'h01;

  // multiply by x in gf(2^8) modulo the aes polynomial x^8 + x^4 + x^3 + x + 1
  // used by mixcolumns and to advance the round constant
  function automatic logic [7:0] xtime(input logic [7:0] b);
    logic [7:0] shifted;
    shifted = {b[6:0], 1'b0};
    // reduce when the top bit falls out of the byte
    if (b[7]) begin
      shifted = shifted ^ 8'h1b;
    end
    return shifted;
  endfunction

endpackage
